// ==== zynq_shell_pkg.sv ====
package zynq_shell_pkg;

   //////////////////////////////////////////////////////////////////////
   // management bus words
   //////////////////////////////////////////////////////////////////////

   typedef logic [31:0] axil_data_t;
   typedef logic [3:0]  axil_strb_t;

   localparam logic [1:0] axil_resp_okay = 2'b00;

   //////////////////////////////////////////////////////////////////////
   // register space, word indexed
   //////////////////////////////////////////////////////////////////////

   typedef logic [7:0] csr_idx_t;

   // bit 0 is the active-low system reset
   localparam csr_idx_t csr_ctrl_idx      = 8'd0;
   localparam csr_idx_t csr_dram_base_idx = 8'd1;

   // first of four profile words, lowest profile bits first
   localparam csr_idx_t csr_prof_idx      = 8'd4;

   //////////////////////////////////////////////////////////////////////
   // address spaces
   //////////////////////////////////////////////////////////////////////

   typedef logic [31:0] phys_addr_t;

   // host port drops the top two bits
   typedef logic [29:0] host_addr_t;

   // start of dram as seen by the core
   localparam phys_addr_t core_dram_base = 32'h8000_0000;

   // clear selects the dram window, set the local window
   localparam int host_sel_bit = 29;

   //////////////////////////////////////////////////////////////////////
   // memory profiler
   //////////////////////////////////////////////////////////////////////

   typedef logic [127:0] profile_t;

   // 7 bit region index from bits 29:23, so 8 MB per region
   localparam int prof_idx_msb   = 29;
   localparam int prof_idx_width = 7;

endpackage

// ==== csr_bus_if.sv ====
`timescale 1ns/1ns

interface csr_bus_if
   import zynq_shell_pkg::*;
   ();

   // single cycle write strobe, no handshake
   logic       wr_v;
   csr_idx_t   wr_idx;
   axil_data_t wr_data;
   axil_strb_t wr_strb;

   // read data follows rd_idx combinationally
   csr_idx_t   rd_idx;
   axil_data_t rd_data;

   modport slave (
      output wr_v
      , output wr_idx
      , output wr_data
      , output wr_strb
      , output rd_idx
      , input  rd_data
   );

   modport regs (
      input    wr_v
      , input  wr_idx
      , input  wr_data
      , input  wr_strb
      , input  rd_idx
      , output rd_data
   );

endinterface

// ==== axil_csr_slave.sv ====
`timescale 1ns/1ns

module axil_csr_slave
   import zynq_shell_pkg::*;
   #(parameter int csr_addr_width_p = 10)
   (input  logic                        aclk_i
    , input  logic                      rst_n_i

    // write address and data, accepted together
    , input  logic [csr_addr_width_p-1:0] awaddr_i
    , input  logic                      awvalid_i
    , output logic                      awready_o
    , input  axil_data_t                wdata_i
    , input  axil_strb_t                wstrb_i
    , input  logic                      wvalid_i
    , output logic                      wready_o

    // write response
    , output logic [1:0]                bresp_o
    , output logic                      bvalid_o
    , input  logic                      bready_i

    // read address
    , input  logic [csr_addr_width_p-1:0] araddr_i
    , input  logic                      arvalid_i
    , output logic                      arready_o

    // read data
    , output axil_data_t                rdata_o
    , output logic [1:0]                rresp_o
    , output logic                      rvalid_o
    , input  logic                      rready_i

    , csr_bus_if.slave                  csr
    );

   logic       bvalid_r;
   logic       rvalid_r;
   axil_data_t rdata_r;
   logic       wr_fire;
   logic       rd_fire;

   //////////////////////////////////////////////////////////////////////
   // acceptance
   //////////////////////////////////////////////////////////////////////

   // both write channels at once, and only with no response pending
   assign wr_fire   = awvalid_i & wvalid_i & ~bvalid_r;
   assign awready_o = wr_fire;
   assign wready_o  = wr_fire;

   // one read outstanding at a time
   assign rd_fire   = arvalid_i & ~rvalid_r;
   assign arready_o = ~rvalid_r;

   // word index is the byte address without its two low bits
   assign csr.wr_v    = wr_fire;
   assign csr.wr_idx  = csr_idx_t'(awaddr_i[csr_addr_width_p-1:2]);
   assign csr.wr_data = wdata_i;
   assign csr.wr_strb = wstrb_i;
   assign csr.rd_idx  = csr_idx_t'(araddr_i[csr_addr_width_p-1:2]);

   //////////////////////////////////////////////////////////////////////
   // response registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bvalid_r <= 1'b0;
      end else if (wr_fire) begin
         bvalid_r <= 1'b1;
      end else if (bready_i) begin
         bvalid_r <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_r <= 1'b0;
      end else if (rd_fire) begin
         rvalid_r <= 1'b1;
      end else if (rready_i) begin
         rvalid_r <= 1'b0;
      end
   end

   // read data is sampled when the address is taken
   always_ff @(posedge aclk_i) begin
      if (rd_fire) begin
         rdata_r <= csr.rd_data;
      end
   end

   // every access completes, so always okay
   assign bresp_o  = axil_resp_okay;
   assign bvalid_o = bvalid_r;
   assign rresp_o  = axil_resp_okay;
   assign rvalid_o = rvalid_r;
   assign rdata_o  = rdata_r;

   // a response stays up, unchanged, until the host takes it
   bvalid_hold_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      bvalid_o && !bready_i |=> bvalid_o)
      else $error("bvalid dropped without bready");

   rvalid_hold_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
      else $error("rvalid or rdata changed without rready");

endmodule

// ==== shell_csr_regs.sv ====
`timescale 1ns/1ns

module shell_csr_regs
   import zynq_shell_pkg::*;
   (input  logic           aclk_i
    , input  logic         rst_n_i
    , csr_bus_if.regs      csr
    , input  profile_t     profile_i
    , output logic         sys_resetn_o
    , output phys_addr_t   dram_base_o
    );

   localparam int prof_words_lp  = $bits(profile_t) / $bits(axil_data_t);
   localparam int prof_sel_w_lp  = $clog2(prof_words_lp);

   axil_data_t               ctrl_r;
   axil_data_t               dram_base_r;
   logic [prof_sel_w_lp-1:0] prof_sel;
   logic                     prof_hit;

   // byte lanes with strobe set take the new data
   function automatic axil_data_t strb_merge(axil_data_t old_w
                                            , axil_data_t new_w
                                            , axil_strb_t strb);
      axil_data_t res;
      res = old_w;
      for (int b = 0; b < $bits(axil_strb_t); b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // host writable registers
   //////////////////////////////////////////////////////////////////////

   // writes to any other index fall on the floor
   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_r      <= '0;
         dram_base_r <= '0;
      end else if (csr.wr_v) begin
         if (csr.wr_idx == csr_ctrl_idx) begin
            ctrl_r <= strb_merge(ctrl_r, csr.wr_data, csr.wr_strb);
         end
         if (csr.wr_idx == csr_dram_base_idx) begin
            dram_base_r <= strb_merge(dram_base_r, csr.wr_data, csr.wr_strb);
         end
      end
   end

   // core reset is held while bit 0 is low
   assign sys_resetn_o = ctrl_r[0];
   assign dram_base_o  = dram_base_r;

   //////////////////////////////////////////////////////////////////////
   // readback
   //////////////////////////////////////////////////////////////////////

   assign prof_hit = (csr.rd_idx >= csr_prof_idx)
                   && (csr.rd_idx < csr_prof_idx + csr_idx_t'(prof_words_lp));
   assign prof_sel = prof_sel_w_lp'(csr.rd_idx - csr_prof_idx);

   // unmapped indices read as zero
   always_comb begin
      csr.rd_data = '0;
      if (csr.rd_idx == csr_ctrl_idx) begin
         csr.rd_data = ctrl_r;
      end else if (csr.rd_idx == csr_dram_base_idx) begin
         csr.rd_data = dram_base_r;
      end else if (prof_hit) begin
         csr.rd_data = profile_i[prof_sel*$bits(axil_data_t) +: $bits(axil_data_t)];
      end
   end

   // the core reset only moves as the result of a host write
   sys_reset_src_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      !$stable(sys_resetn_o) |-> $past(csr.wr_v) && $past(csr.wr_idx) == csr_ctrl_idx)
      else $error("sys_resetn changed without a control write");

endmodule

// ==== addr_map.sv ====
`timescale 1ns/1ns

module addr_map
   import zynq_shell_pkg::*;
   (input  host_addr_t     host_awaddr_i
    , input  host_addr_t   host_araddr_i
    , output phys_addr_t   core_awaddr_o
    , output phys_addr_t   core_araddr_o

    , input  phys_addr_t   core_dram_awaddr_i
    , input  phys_addr_t   core_dram_araddr_i
    , input  phys_addr_t   dram_base_i
    , output phys_addr_t   dram_awaddr_o
    , output phys_addr_t   dram_araddr_o
    );

   // only 256 MB per window is mapped, so this bit must stay clear
   localparam int host_hole_bit_lp = host_sel_bit - 1;

   //////////////////////////////////////////////////////////////////////
   // host window into the core
   //////////////////////////////////////////////////////////////////////

   // 0x0xxx_xxxx goes to core dram at 0x8xxx_xxxx
   // 0x2xxx_xxxx goes to core local space at 0x0xxx_xxxx
   function automatic phys_addr_t host_to_core(host_addr_t h);
      return {~h[host_sel_bit], 3'b000, h[host_hole_bit_lp-1:0]};
   endfunction

   assign core_awaddr_o = host_to_core(host_awaddr_i);
   assign core_araddr_o = host_to_core(host_araddr_i);

   always_comb begin
      host_aw_hole_a: assert #0 (host_awaddr_i[host_hole_bit_lp] !== 1'b1)
         else $error("host write address outside the mapped window");
      host_ar_hole_a: assert #0 (host_araddr_i[host_hole_bit_lp] !== 1'b1)
         else $error("host read address outside the mapped window");
   end

   //////////////////////////////////////////////////////////////////////
   // core dram into host memory
   //////////////////////////////////////////////////////////////////////

   // strip the core's dram base, then rebase onto the host buffer
   function automatic phys_addr_t core_to_dram(phys_addr_t a, phys_addr_t base);
      return (a ^ core_dram_base) + base;
   endfunction

   assign dram_awaddr_o = core_to_dram(core_dram_awaddr_i, dram_base_i);
   assign dram_araddr_o = core_to_dram(core_dram_araddr_i, dram_base_i);

endmodule

// ==== mem_profiler.sv ====
`timescale 1ns/1ns

module mem_profiler
   import zynq_shell_pkg::*;
   (input  logic           aclk_i
    , input  logic         rst_n_i
    , input  logic         sys_resetn_i
    , input  logic         dram_awvalid_i
    , input  logic         dram_arvalid_i
    , input  phys_addr_t   dram_awaddr_i
    , input  phys_addr_t   dram_araddr_i
    , output profile_t     profile_o
    );

   logic [prof_idx_width-1:0] aw_region;
   logic [prof_idx_width-1:0] ar_region;
   profile_t                  aw_hit;
   profile_t                  ar_hit;
   profile_t                  profile_r;

   // region index straight from the untranslated core address
   assign aw_region = dram_awaddr_i[prof_idx_msb -: prof_idx_width];
   assign ar_region = dram_araddr_i[prof_idx_msb -: prof_idx_width];

   // valid alone marks a touch, ready is not needed
   assign aw_hit = profile_t'(dram_awvalid_i) << aw_region;
   assign ar_hit = profile_t'(dram_arvalid_i) << ar_region;

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         profile_r <= '0;
      end else if (!sys_resetn_i) begin
         profile_r <= '0;
      end else begin
         profile_r <= profile_r | aw_hit | ar_hit;
      end
   end

   assign profile_o = profile_r;

   // bits are sticky until the core goes back into reset
   profile_sticky_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      $past(sys_resetn_i) |-> ($past(profile_r) & ~profile_r) == '0)
      else $error("profile bit cleared while core out of reset");

endmodule

// ==== zynq_shell_top.sv ====
`timescale 1ns/1ns

module zynq_shell_top
   import zynq_shell_pkg::*;
   #(parameter int csr_addr_width_p = 10)
   (input  logic                          aclk_i
    , input  logic                        rst_n_i

    // management port from the host
    , input  logic [csr_addr_width_p-1:0] s00_awaddr_i
    , input  logic                        s00_awvalid_i
    , output logic                        s00_awready_o
    , input  axil_data_t                  s00_wdata_i
    , input  axil_strb_t                  s00_wstrb_i
    , input  logic                        s00_wvalid_i
    , output logic                        s00_wready_o
    , output logic [1:0]                  s00_bresp_o
    , output logic                        s00_bvalid_o
    , input  logic                        s00_bready_i
    , input  logic [csr_addr_width_p-1:0] s00_araddr_i
    , input  logic                        s00_arvalid_i
    , output logic                        s00_arready_o
    , output axil_data_t                  s00_rdata_o
    , output logic [1:0]                  s00_rresp_o
    , output logic                        s00_rvalid_o
    , input  logic                        s00_rready_i

    // host window into the core
    , input  host_addr_t                  host_awaddr_i
    , input  host_addr_t                  host_araddr_i
    , output phys_addr_t                  core_awaddr_o
    , output phys_addr_t                  core_araddr_o

    // core dram traffic
    , input  phys_addr_t                  core_dram_awaddr_i
    , input  logic                        core_dram_awvalid_i
    , input  phys_addr_t                  core_dram_araddr_i
    , input  logic                        core_dram_arvalid_i
    , output phys_addr_t                  dram_awaddr_o
    , output phys_addr_t                  dram_araddr_o

    , output logic                        sys_resetn_o
    );

   profile_t   profile;
   phys_addr_t dram_base;
   logic       sys_resetn;

   csr_bus_if csr_bus ();

   //////////////////////////////////////////////////////////////////////
   // control and status
   //////////////////////////////////////////////////////////////////////

   axil_csr_slave #(.csr_addr_width_p(csr_addr_width_p)) slave
      (.aclk_i     (aclk_i)
       ,.rst_n_i   (rst_n_i)
       ,.awaddr_i  (s00_awaddr_i)
       ,.awvalid_i (s00_awvalid_i)
       ,.awready_o (s00_awready_o)
       ,.wdata_i   (s00_wdata_i)
       ,.wstrb_i   (s00_wstrb_i)
       ,.wvalid_i  (s00_wvalid_i)
       ,.wready_o  (s00_wready_o)
       ,.bresp_o   (s00_bresp_o)
       ,.bvalid_o  (s00_bvalid_o)
       ,.bready_i  (s00_bready_i)
       ,.araddr_i  (s00_araddr_i)
       ,.arvalid_i (s00_arvalid_i)
       ,.arready_o (s00_arready_o)
       ,.rdata_o   (s00_rdata_o)
       ,.rresp_o   (s00_rresp_o)
       ,.rvalid_o  (s00_rvalid_o)
       ,.rready_i  (s00_rready_i)
       ,.csr       (csr_bus)
       );

   shell_csr_regs regs
      (.aclk_i        (aclk_i)
       ,.rst_n_i      (rst_n_i)
       ,.csr          (csr_bus)
       ,.profile_i    (profile)
       ,.sys_resetn_o (sys_resetn)
       ,.dram_base_o  (dram_base)
       );

   assign sys_resetn_o = sys_resetn;

   //////////////////////////////////////////////////////////////////////
   // address translation and profiling
   //////////////////////////////////////////////////////////////////////

   addr_map map
      (.host_awaddr_i       (host_awaddr_i)
       ,.host_araddr_i      (host_araddr_i)
       ,.core_awaddr_o      (core_awaddr_o)
       ,.core_araddr_o      (core_araddr_o)
       ,.core_dram_awaddr_i (core_dram_awaddr_i)
       ,.core_dram_araddr_i (core_dram_araddr_i)
       ,.dram_base_i        (dram_base)
       ,.dram_awaddr_o      (dram_awaddr_o)
       ,.dram_araddr_o      (dram_araddr_o)
       );

   // profiler sees core addresses before translation
   mem_profiler prof
      (.aclk_i          (aclk_i)
       ,.rst_n_i        (rst_n_i)
       ,.sys_resetn_i   (sys_resetn)
       ,.dram_awvalid_i (core_dram_awvalid_i)
       ,.dram_arvalid_i (core_dram_arvalid_i)
       ,.dram_awaddr_i  (core_dram_awaddr_i)
       ,.dram_araddr_i  (core_dram_araddr_i)
       ,.profile_o      (profile)
       );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen
   #(parameter int period_p       = 10
     , parameter int reset_cycles_p = 16)
   (output logic   clk_o
    , output logic rst_n_o
    );

   initial begin
      clk_o = 1'b0;
      forever begin
         #(period_p / 2) clk_o = ~clk_o;
      end
   end

   // release just after an edge so no flop sees it change on the edge
   initial begin
      rst_n_o = 1'b0;
      repeat (reset_cycles_p) @(posedge clk_o);
      #1 rst_n_o = 1'b1;
   end

endmodule

// ==== tb_zynq_shell.sv ====
`timescale 1ns/1ns

module tb_zynq_shell
   import zynq_shell_pkg::*;
   ();

   localparam int period_lp  = 10;
   localparam int n_rand_lp  = 40;
   localparam int n_bp_lp    = 8;
   localparam int n_host_lp  = 50;
   localparam int n_pulse_lp = 60;
   localparam int n_idle_lp  = 20;
   // each operation below fits in 20 cycles
   localparam int n_ops_lp   = 6 + 2 * n_rand_lp + 2 * n_bp_lp + n_host_lp
                             + n_pulse_lp + n_idle_lp + 16;
   localparam int timeout_lp = (n_ops_lp * 20 + 216) * period_lp;

   logic       clk;
   logic       rst_n;
   logic [9:0] s00_awaddr;
   logic       s00_awvalid;
   logic       s00_awready;
   axil_data_t s00_wdata;
   axil_strb_t s00_wstrb;
   logic       s00_wvalid;
   logic       s00_wready;
   logic [1:0] s00_bresp;
   logic       s00_bvalid;
   logic       s00_bready;
   logic [9:0] s00_araddr;
   logic       s00_arvalid;
   logic       s00_arready;
   axil_data_t s00_rdata;
   logic [1:0] s00_rresp;
   logic       s00_rvalid;
   logic       s00_rready;
   host_addr_t host_awaddr;
   host_addr_t host_araddr;
   phys_addr_t core_awaddr;
   phys_addr_t core_araddr;
   phys_addr_t core_dram_awaddr;
   logic       core_dram_awvalid;
   phys_addr_t core_dram_araddr;
   logic       core_dram_arvalid;
   phys_addr_t dram_awaddr;
   phys_addr_t dram_araddr;
   logic       sys_resetn;

   // reference model of the host visible state
   axil_data_t  model_ctrl;
   axil_data_t  model_base;
   profile_t    model_prof;
   logic [31:0] lcg_state;

   tb_clk_gen #(.period_p(period_lp), .reset_cycles_p(16)) u_clk
      (.clk_o    (clk)
       ,.rst_n_o (rst_n)
       );

   zynq_shell_top #(.csr_addr_width_p(10)) u_dut
      (.aclk_i               (clk)
       ,.rst_n_i             (rst_n)
       ,.s00_awaddr_i        (s00_awaddr)
       ,.s00_awvalid_i       (s00_awvalid)
       ,.s00_awready_o       (s00_awready)
       ,.s00_wdata_i         (s00_wdata)
       ,.s00_wstrb_i         (s00_wstrb)
       ,.s00_wvalid_i        (s00_wvalid)
       ,.s00_wready_o        (s00_wready)
       ,.s00_bresp_o         (s00_bresp)
       ,.s00_bvalid_o        (s00_bvalid)
       ,.s00_bready_i        (s00_bready)
       ,.s00_araddr_i        (s00_araddr)
       ,.s00_arvalid_i       (s00_arvalid)
       ,.s00_arready_o       (s00_arready)
       ,.s00_rdata_o         (s00_rdata)
       ,.s00_rresp_o         (s00_rresp)
       ,.s00_rvalid_o        (s00_rvalid)
       ,.s00_rready_i        (s00_rready)
       ,.host_awaddr_i       (host_awaddr)
       ,.host_araddr_i       (host_araddr)
       ,.core_awaddr_o       (core_awaddr)
       ,.core_araddr_o       (core_araddr)
       ,.core_dram_awaddr_i  (core_dram_awaddr)
       ,.core_dram_awvalid_i (core_dram_awvalid)
       ,.core_dram_araddr_i  (core_dram_araddr)
       ,.core_dram_arvalid_i (core_dram_arvalid)
       ,.dram_awaddr_o       (dram_awaddr)
       ,.dram_araddr_o       (dram_araddr)
       ,.sys_resetn_o        (sys_resetn)
       );

   //////////////////////////////////////////////////////////////////////
   // random numbers and expected values
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // low lcg bits repeat quickly, so only the upper half is used
   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = next_rand();
      return int'(r[31:16]) % n;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[31:16], lo[31:16]};
   endfunction

   function automatic axil_data_t lane_mask(input axil_strb_t strb);
      return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
   endfunction

   // set bit 29 selects local space at zero, clear selects dram at 0x8000_0000
   function automatic phys_addr_t host_expect(input host_addr_t h);
      if (h[29]) begin
         return {4'h0, h[27:0]};
      end else begin
         return {4'h8, h[27:0]};
      end
   endfunction

   function automatic axil_data_t read_expect(input csr_idx_t idx);
      case (idx)
         8'd0:    return model_ctrl;
         8'd1:    return model_base;
         8'd4:    return model_prof[31:0];
         8'd5:    return model_prof[63:32];
         8'd6:    return model_prof[95:64];
         8'd7:    return model_prof[127:96];
         default: return '0;
      endcase
   endfunction

   task automatic check_eq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // management bus transactions
   //////////////////////////////////////////////////////////////////////

   task automatic axil_write(input csr_idx_t idx, input axil_data_t data,
                             input axil_strb_t strb, input int hold);
      axil_data_t mask;
      int         i;
      @(posedge clk);
      #1;
      s00_awaddr  = {idx, 2'b00};
      s00_wdata   = data;
      s00_wstrb   = strb;
      s00_awvalid = 1'b1;
      s00_wvalid  = 1'b1;
      #1;
      while (!(s00_awready && s00_wready)) begin
         @(posedge clk);
         #2;
      end
      @(posedge clk);
      #1;
      mask = lane_mask(strb);
      if (idx == 8'd0) begin
         model_ctrl = (model_ctrl & ~mask) | (data & mask);
      end
      if (idx == 8'd1) begin
         model_base = (model_base & ~mask) | (data & mask);
      end
      // core held in reset wipes the profile
      if (!model_ctrl[0]) begin
         model_prof = '0;
      end
      while (!s00_bvalid) begin
         @(posedge clk);
         #1;
      end
      // keep a second write on offer while the response is stalled
      s00_wdata = rand_word();
      for (i = 0; i < hold; i++) begin
         check_eq("bvalid", s00_bvalid, 1'b1);
         check_eq("awready", s00_awready, 1'b0);
         check_eq("wready", s00_wready, 1'b0);
         @(posedge clk);
         #1;
      end
      check_eq("bvalid", s00_bvalid, 1'b1);
      check_eq("bresp", s00_bresp, 2'b00);
      s00_awvalid = 1'b0;
      s00_wvalid  = 1'b0;
      s00_bready  = 1'b1;
      @(posedge clk);
      #1;
      s00_bready = 1'b0;
      check_eq("bvalid", s00_bvalid, 1'b0);
      check_eq("sys_resetn_o", sys_resetn, model_ctrl[0]);
   endtask

   task automatic axil_read_check(input csr_idx_t idx, input int hold);
      axil_data_t first;
      int         i;
      @(posedge clk);
      #1;
      s00_araddr  = {idx, 2'b00};
      s00_arvalid = 1'b1;
      #1;
      while (!s00_arready) begin
         @(posedge clk);
         #2;
      end
      @(posedge clk);
      #1;
      while (!s00_rvalid) begin
         @(posedge clk);
         #1;
      end
      first = s00_rdata;
      // a read of another index must not replace the pending data
      s00_araddr = {csr_idx_t'(rand_below(256)), 2'b00};
      for (i = 0; i < hold; i++) begin
         check_eq("rvalid", s00_rvalid, 1'b1);
         check_eq("arready", s00_arready, 1'b0);
         check_eq("rdata", s00_rdata, first);
         @(posedge clk);
         #1;
      end
      check_eq("rvalid", s00_rvalid, 1'b1);
      check_eq("rresp", s00_rresp, 2'b00);
      check_eq($sformatf("rdata[%0d]", idx), s00_rdata, read_expect(idx));
      s00_arvalid = 1'b0;
      s00_rready  = 1'b1;
      @(posedge clk);
      #1;
      s00_rready = 1'b0;
      check_eq("rvalid", s00_rvalid, 1'b0);
   endtask

   task automatic read_profile();
      int k;
      for (k = 0; k < 4; k++) begin
         axil_read_check(csr_prof_idx + csr_idx_t'(k), rand_below(3));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // address paths
   //////////////////////////////////////////////////////////////////////

   task automatic host_check();
      host_addr_t ha;
      host_addr_t hr;
      ha = host_addr_t'(rand_word());
      hr = host_addr_t'(rand_word());
      ha[28] = 1'b0;
      hr[28] = 1'b0;
      @(posedge clk);
      #1;
      host_awaddr = ha;
      host_araddr = hr;
      #1;
      check_eq("core_awaddr_o", core_awaddr, host_expect(ha));
      check_eq("core_araddr_o", core_araddr, host_expect(hr));
   endtask

   task automatic core_pulse(input logic aw_v, input logic ar_v);
      phys_addr_t aw_a;
      phys_addr_t ar_a;
      aw_a = rand_word();
      ar_a = rand_word();
      @(posedge clk);
      #1;
      core_dram_awaddr  = aw_a;
      core_dram_araddr  = ar_a;
      core_dram_awvalid = aw_v;
      core_dram_arvalid = ar_v;
      #1;
      // core dram starts at 0x8000_0000, host buffer at the programmed base
      check_eq("dram_awaddr_o", dram_awaddr, aw_a - 32'h8000_0000 + model_base);
      check_eq("dram_araddr_o", dram_araddr, ar_a - 32'h8000_0000 + model_base);
      @(posedge clk);
      #1;
      core_dram_awvalid = 1'b0;
      core_dram_arvalid = 1'b0;
      if (model_ctrl[0] && aw_v) begin
         model_prof[aw_a[29:23]] = 1'b1;
      end
      if (model_ctrl[0] && ar_v) begin
         model_prof[ar_a[29:23]] = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      #(timeout_lp);
      $display("timeout: tests still running after %0d ns", timeout_lp);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int       i;
      csr_idx_t idx;
      s00_awaddr        = '0;
      s00_awvalid       = 1'b0;
      s00_wdata         = '0;
      s00_wstrb         = '0;
      s00_wvalid        = 1'b0;
      s00_bready        = 1'b0;
      s00_araddr        = '0;
      s00_arvalid       = 1'b0;
      s00_rready        = 1'b0;
      host_awaddr       = '0;
      host_araddr       = '0;
      core_dram_awaddr  = '0;
      core_dram_awvalid = 1'b0;
      core_dram_araddr  = '0;
      core_dram_arvalid = 1'b0;
      lcg_state         = 32'd77;
      model_ctrl        = '0;
      model_base        = '0;
      model_prof        = '0;

      @(posedge rst_n);
      @(posedge clk);
      #1;
      check_eq("sys_resetn_o", sys_resetn, 1'b0);
      check_eq("bvalid", s00_bvalid, 1'b0);
      check_eq("rvalid", s00_rvalid, 1'b0);
      axil_read_check(csr_ctrl_idx, 0);
      axil_read_check(csr_dram_base_idx, 0);
      read_profile();

      // mapped and unmapped indices with random strobes
      for (i = 0; i < n_rand_lp; i++) begin
         if (rand_below(4) == 0) begin
            idx = csr_idx_t'(8 + rand_below(248));
         end else begin
            idx = csr_idx_t'(rand_below(8));
         end
         axil_write(idx, rand_word(), axil_strb_t'(rand_below(16)), rand_below(4));
         axil_read_check(idx, rand_below(4));
      end

      // long response stalls
      for (i = 0; i < n_bp_lp; i++) begin
         idx = csr_idx_t'(rand_below(2));
         axil_write(idx, rand_word(), 4'hf, 4 + rand_below(12));
         axil_read_check(idx, 4 + rand_below(12));
      end

      for (i = 0; i < n_host_lp; i++) begin
         host_check();
      end

      axil_write(csr_ctrl_idx, 32'h1, 4'hf, 0);
      axil_write(csr_dram_base_idx, rand_word(), 4'hf, 0);
      axil_read_check(csr_dram_base_idx, 0);
      for (i = 0; i < n_pulse_lp; i++) begin
         core_pulse(1'(rand_below(2)), 1'(rand_below(2)));
      end
      read_profile();

      // core back into reset clears the profile and stops recording
      axil_write(csr_ctrl_idx, 32'h0, 4'h1, 1);
      read_profile();
      for (i = 0; i < n_idle_lp; i++) begin
         core_pulse(1'b1, 1'b1);
      end
      read_profile();

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== vlog.f ====
zynq_shell_pkg.sv
csr_bus_if.sv
axil_csr_slave.sv
shell_csr_regs.sv
addr_map.sv
mem_profiler.sv
zynq_shell_top.sv
tb_clk_gen.sv
tb_zynq_shell.sv
